//--- rtl/fbPkg.sv
package fbPkg;

    localparam int ADDR_W        = 16;                     // Memory word address
    localparam int DATA_W        = 32;                     // Pixel word
    localparam int BURST_LEN     = 8;                      // Beats per burst
    localparam int WR_FIFO_DEPTH = 16;
    localparam int RD_FIFO_DEPTH = 16;
    localparam int WR_CNT_W      = $clog2(WR_FIFO_DEPTH + 1);
    localparam int RD_CNT_W      = $clog2(RD_FIFO_DEPTH + 1);
    localparam int BEAT_W        = $clog2(BURST_LEN);

    typedef logic [DATA_W-1:0] pixelWord;
    typedef logic [ADDR_W-1:0] memAddr;

    // --------------------------------------------------
    // Next burst base inside an address window
    function automatic memAddr ringNext(memAddr addr, memAddr winMin, memAddr winMax);
        logic [ADDR_W:0] nextLast;                         // Last word of next burst
        nextLast = {1'b0, addr} + (ADDR_W + 1)'(2 * BURST_LEN - 1);
        if (nextLast > {1'b0, winMax})
            return winMin;                                 // Would pass the max, wrap
        return addr + ADDR_W'(BURST_LEN);
    endfunction

endpackage

//--- rtl/burstFifo.sv
`timescale 1ns/1ps

module burstFifo
#(
    parameter int DEPTH = 16,
    parameter int PTR_W = $clog2(DEPTH),
    parameter int CNT_W = $clog2(DEPTH + 1)
)
(
    input  logic             REF_CLK,
    input  logic             RESET_N,
    input  logic             clear,                        // Flush on window load
    input  logic             push,
    input  fbPkg::pixelWord  pushData,
    input  logic             pop,
    output fbPkg::pixelWord  popData,                      // Valid the cycle after pop
    output logic [CNT_W-1:0] count,
    output logic             full,
    output logic             empty
);

    fbPkg::pixelWord  mem [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic             pushOk;
    logic             popOk;

    assign pushOk = push & ~full;                          // Drop pushes when full
    assign popOk  = pop & ~empty;
    assign full   = (count == CNT_W'(DEPTH));
    assign empty  = (count == '0);

    always_ff @(posedge REF_CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else if (clear)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (pushOk)
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (popOk)
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            if (pushOk && !popOk)
                count <= count + 1'b1;
            else if (popOk && !pushOk)
                count <= count - 1'b1;
        end
    end

    // Storage and output register
    always_ff @(posedge REF_CLK)
    begin
        if (pushOk)
            mem[wrPtr] <= pushData;
        if (popOk)
            popData <= mem[rdPtr];
    end

endmodule

//--- rtl/writeChannel.sv
`timescale 1ns/1ps

module writeChannel
(
    input  logic            REF_CLK,
    input  logic            RESET_N,
    input  fbPkg::pixelWord wrData,
    input  logic            wrPush,
    output logic            wrFull,
    input  logic            wrLoad,
    input  fbPkg::memAddr   wrWinMin,
    input  fbPkg::memAddr   wrWinMax,
    output logic            burstReq,
    output fbPkg::memAddr   burstAddr,
    output fbPkg::pixelWord beatData,                      // Head of queue
    input  logic            beatTake,
    input  logic            burstDone
);

    logic [fbPkg::WR_CNT_W-1:0] fifoCount;
    logic [fbPkg::WR_CNT_W-1:0] queued;
    logic                       fifoEmpty;
    logic                       fifoPop;
    logic                       headValid;                 // FIFO output reg holds a word
    fbPkg::memAddr              winMin;
    fbPkg::memAddr              winMax;
    fbPkg::memAddr              ringAddr;

    // Prefetch keeps the head word sitting on the FIFO output
    assign fifoPop   = (~headValid | beatTake) & ~fifoEmpty;
    assign queued    = fifoCount + fbPkg::WR_CNT_W'(headValid);
    assign wrFull    = (queued == fbPkg::WR_CNT_W'(fbPkg::WR_FIFO_DEPTH));
    assign burstAddr = ringAddr;

    burstFifo #(.DEPTH(fbPkg::WR_FIFO_DEPTH)) i_wrFifo
    (
        .REF_CLK  (REF_CLK),
        .RESET_N  (RESET_N),
        .clear    (wrLoad),
        .push     (wrPush & ~wrFull),
        .pushData (wrData),
        .pop      (fifoPop),
        .popData  (beatData),
        .count    (fifoCount),
        .full     (),
        .empty    (fifoEmpty)
    );

    always_ff @(posedge REF_CLK or negedge RESET_N)
    begin
        if (!RESET_N)
            headValid <= 1'b0;
        else if (wrLoad)
            headValid <= 1'b0;
        else if (fifoPop)
            headValid <= 1'b1;
        else if (beatTake)
            headValid <= 1'b0;                             // Last word taken
    end

    // --------------------------------------------------
    // Window and address ring
    always_ff @(posedge REF_CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            winMin   <= '0;
            winMax   <= '0;
            ringAddr <= '0;
        end
        else if (wrLoad)
        begin
            winMin   <= wrWinMin;
            winMax   <= wrWinMax;
            ringAddr <= wrWinMin;
        end
        else if (burstDone)
            ringAddr <= fbPkg::ringNext(ringAddr, winMin, winMax);
    end

    always_ff @(posedge REF_CLK or negedge RESET_N)
    begin
        if (!RESET_N)
            burstReq <= 1'b0;
        else if (burstDone)
            burstReq <= 1'b0;
        else if (!burstReq && !wrLoad && queued >= fbPkg::WR_CNT_W'(fbPkg::BURST_LEN))
            burstReq <= 1'b1;                              // Full burst queued
    end

endmodule

//--- rtl/readChannel.sv
`timescale 1ns/1ps

module readChannel
(
    input  logic            REF_CLK,
    input  logic            RESET_N,
    output fbPkg::pixelWord rdData,
    input  logic            rdPop,
    output logic            rdEmpty,
    input  logic            rdLoad,
    input  fbPkg::memAddr   rdWinMin,
    input  fbPkg::memAddr   rdWinMax,
    input  logic            rdEnable,
    output logic            burstReq,
    output fbPkg::memAddr   burstAddr,
    input  fbPkg::pixelWord beatData,
    input  logic            beatPut,
    input  logic            burstDone
);

    logic [fbPkg::RD_CNT_W-1:0] fifoCount;
    logic [fbPkg::RD_CNT_W-1:0] freeSpace;
    logic                       roomOk;
    fbPkg::memAddr              winMin;
    fbPkg::memAddr              winMax;
    fbPkg::memAddr              ringAddr;

    // All beats have landed by the time the request drops, so the
    // count alone covers what is in flight
    assign freeSpace = fbPkg::RD_CNT_W'(fbPkg::RD_FIFO_DEPTH) - fifoCount;
    assign roomOk    = (freeSpace >= fbPkg::RD_CNT_W'(fbPkg::BURST_LEN));
    assign burstAddr = ringAddr;

    burstFifo #(.DEPTH(fbPkg::RD_FIFO_DEPTH)) i_rdFifo
    (
        .REF_CLK  (REF_CLK),
        .RESET_N  (RESET_N),
        .clear    (rdLoad),
        .push     (beatPut),
        .pushData (beatData),
        .pop      (rdPop),
        .popData  (rdData),
        .count    (fifoCount),
        .full     (),
        .empty    (rdEmpty)
    );

    // --------------------------------------------------
    // Window and address ring
    always_ff @(posedge REF_CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            winMin   <= '0;
            winMax   <= '0;
            ringAddr <= '0;
        end
        else if (rdLoad)
        begin
            winMin   <= rdWinMin;
            winMax   <= rdWinMax;
            ringAddr <= rdWinMin;                          // Restart at new minimum
        end
        else if (burstDone)
            ringAddr <= fbPkg::ringNext(ringAddr, winMin, winMax);
    end

    always_ff @(posedge REF_CLK or negedge RESET_N)
    begin
        if (!RESET_N)
            burstReq <= 1'b0;
        else if (burstDone)
            burstReq <= 1'b0;
        else if (!burstReq && !rdLoad && rdEnable && roomOk)
            burstReq <= 1'b1;
    end

endmodule

//--- rtl/burstArbiter.sv
`timescale 1ns/1ps

module burstArbiter
(
    input  logic            REF_CLK,
    input  logic            RESET_N,
    input  logic            wrReq,
    input  fbPkg::memAddr   wrAddr,
    input  fbPkg::pixelWord wrBeat,
    output logic            wrTake,
    output logic            wrDone,
    input  logic            rdReq,
    input  fbPkg::memAddr   rdAddr,
    output fbPkg::pixelWord rdBeat,
    output logic            rdPut,
    output logic            rdDone,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output fbPkg::memAddr   wbAdr,
    output fbPkg::pixelWord wbDatOut,
    input  fbPkg::pixelWord wbDatIn,
    input  logic            wbAck
);

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_BEAT,                                           // Strobe up, waiting for ack
        ST_GAP                                             // Strobe low for one cycle
    } arbState;

    arbState                  state;
    logic [fbPkg::BEAT_W-1:0] beatCnt;
    logic                     isWrite;                     // Direction of current burst
    logic                     lastBeat;
    logic                     beatAck;
    fbPkg::memAddr            baseAddr;

    assign lastBeat = (beatCnt == fbPkg::BEAT_W'(fbPkg::BURST_LEN - 1));
    assign beatAck  = (state == ST_BEAT) & wbAck;
    assign wrTake   = beatAck & isWrite;                   // Pops the queue head
    assign wbDatOut = isWrite ? wrBeat : '0;

    always_ff @(posedge REF_CLK or negedge RESET_N)
    begin
        if (!RESET_N)
        begin
            state    <= ST_IDLE;
            beatCnt  <= '0;
            isWrite  <= 1'b0;
            baseAddr <= '0;
            wbCyc    <= 1'b0;
            wbStb    <= 1'b0;
            wbWe     <= 1'b0;
            wbAdr    <= '0;
            wrDone   <= 1'b0;
            rdDone   <= 1'b0;
            rdPut    <= 1'b0;
        end
        else
        begin
            wrDone <= 1'b0;
            rdDone <= 1'b0;
            rdPut  <= beatAck & ~isWrite;
            case (state)
                ST_IDLE:
                begin
                    if (wrReq || rdReq)
                    begin
                        isWrite  <= wrReq;                 // Write wins a tie
                        baseAddr <= wrReq ? wrAddr : rdAddr;
                        wbAdr    <= wrReq ? wrAddr : rdAddr;
                        wbWe     <= wrReq;
                        wbCyc    <= 1'b1;
                        wbStb    <= 1'b1;
                        beatCnt  <= '0;
                        state    <= ST_BEAT;
                    end
                end
                ST_BEAT:
                begin
                    if (wbAck)
                    begin
                        wbStb <= 1'b0;
                        state <= ST_GAP;
                        if (lastBeat)
                        begin
                            wbCyc  <= 1'b0;
                            wbWe   <= 1'b0;
                            wrDone <= isWrite;
                            rdDone <= ~isWrite;
                        end
                        else
                            beatCnt <= beatCnt + 1'b1;
                    end
                end
                ST_GAP:
                begin
                    if (wbCyc)
                    begin
                        wbStb <= 1'b1;
                        wbAdr <= baseAddr + fbPkg::ADDR_W'(beatCnt);
                        state <= ST_BEAT;
                    end
                    else
                        state <= ST_IDLE;                  // Burst finished
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Read data capture
    always_ff @(posedge REF_CLK)
    begin
        if (beatAck && !isWrite)
            rdBeat <= wbDatIn;
    end

endmodule

//--- rtl/frameBufferCtrl.sv
`timescale 1ns/1ps

module frameBufferCtrl
(
    input  logic            REF_CLK,
    input  logic            RESET_N,
    // Host write side
    input  fbPkg::pixelWord wrData,
    input  logic            wrPush,
    output logic            wrFull,
    input  logic            wrLoad,
    input  fbPkg::memAddr   wrWinMin,
    input  fbPkg::memAddr   wrWinMax,
    // Host read side
    output fbPkg::pixelWord rdData,
    input  logic            rdPop,
    output logic            rdEmpty,
    input  logic            rdLoad,
    input  fbPkg::memAddr   rdWinMin,
    input  fbPkg::memAddr   rdWinMax,
    input  logic            rdEnable,
    // Wishbone master
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output fbPkg::memAddr   wbAdr,
    output fbPkg::pixelWord wbDatOut,
    input  fbPkg::pixelWord wbDatIn,
    input  logic            wbAck
);

    logic            wrReq;
    fbPkg::memAddr   wrAddr;
    fbPkg::pixelWord wrBeat;
    logic            wrTake;
    logic            wrDone;
    logic            rdReq;
    fbPkg::memAddr   rdAddr;
    fbPkg::pixelWord rdBeat;
    logic            rdPut;
    logic            rdDone;

    writeChannel i_wrChan
    (
        .REF_CLK   (REF_CLK),
        .RESET_N   (RESET_N),
        .wrData    (wrData),
        .wrPush    (wrPush),
        .wrFull    (wrFull),
        .wrLoad    (wrLoad),
        .wrWinMin  (wrWinMin),
        .wrWinMax  (wrWinMax),
        .burstReq  (wrReq),
        .burstAddr (wrAddr),
        .beatData  (wrBeat),
        .beatTake  (wrTake),
        .burstDone (wrDone)
    );

    readChannel i_rdChan
    (
        .REF_CLK   (REF_CLK),
        .RESET_N   (RESET_N),
        .rdData    (rdData),
        .rdPop     (rdPop),
        .rdEmpty   (rdEmpty),
        .rdLoad    (rdLoad),
        .rdWinMin  (rdWinMin),
        .rdWinMax  (rdWinMax),
        .rdEnable  (rdEnable),
        .burstReq  (rdReq),
        .burstAddr (rdAddr),
        .beatData  (rdBeat),
        .beatPut   (rdPut),
        .burstDone (rdDone)
    );

    burstArbiter i_arb
    (
        .REF_CLK  (REF_CLK),
        .RESET_N  (RESET_N),
        .wrReq    (wrReq),
        .wrAddr   (wrAddr),
        .wrBeat   (wrBeat),
        .wrTake   (wrTake),
        .wrDone   (wrDone),
        .rdReq    (rdReq),
        .rdAddr   (rdAddr),
        .rdBeat   (rdBeat),
        .rdPut    (rdPut),
        .rdDone   (rdDone),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbAdr    (wbAdr),
        .wbDatOut (wbDatOut),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck)
    );

endmodule

//--- sim/fbCtrl_props.sv
`timescale 1ns/1ps

module fbCtrlProps
(
    input logic          REF_CLK,
    input logic          RESET_N,
    input logic          wbCyc,
    input logic          wbStb,
    input logic          wbWe,
    input logic          wbAck,
    input fbPkg::memAddr wbAdr,
    input logic          wrPush,
    input logic          wrFull,
    input logic          wrLoad,
    input logic          wrTake
);

    assert property (@(posedge REF_CLK) disable iff (!RESET_N) wbStb |-> wbCyc)
        else $error("wbStb high while wbCyc is low");

    // Beat held until its ack
    assert property (@(posedge REF_CLK) disable iff (!RESET_N)
                     (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe)))
        else $error("wbAdr or wbWe changed during a pending beat");

    assert property (@(posedge REF_CLK) !RESET_N |-> !wbCyc)
        else $error("wbCyc high during reset");

    // An accepted push into a full queue would lift wrFull
    assert property (@(posedge REF_CLK) disable iff (!RESET_N)
                     (wrPush && wrFull && !wrTake && !wrLoad) |=> wrFull)
        else $error("Push accepted while the write queue was full");

endmodule

bind frameBufferCtrl fbCtrlProps i_props
(
    .REF_CLK (REF_CLK),
    .RESET_N (RESET_N),
    .wbCyc   (wbCyc),
    .wbStb   (wbStb),
    .wbWe    (wbWe),
    .wbAck   (wbAck),
    .wbAdr   (wbAdr),
    .wrPush  (wrPush),
    .wrFull  (wrFull),
    .wrLoad  (wrLoad),
    .wrTake  (wrTake)
);

//--- sim/tbFrameBuffer.sv
`timescale 1ns/1ps

module tbFrameBuffer;

    logic            REF_CLK;
    logic            RESET_N;
    logic            wrPush, wrFull, wrLoad;
    logic            rdPop, rdEmpty, rdLoad, rdEnable;
    logic            wbCyc, wbStb, wbWe, wbAck;
    fbPkg::pixelWord wrData, rdData, wbDatOut, wbDatIn;
    fbPkg::memAddr   winMin, winMax, wbAdr;

    // Test table from the stimulus file
    string           rowName [16];
    int              rowMode [16];
    fbPkg::memAddr   rowMin [16];
    fbPkg::memAddr   rowMax [16];
    fbPkg::pixelWord rowSeed [16];
    int              rowBursts [16];
    fbPkg::memAddr   rowExp [16][4];
    int              rowCount = 0;
    int              totalBursts = 0;

    // Slave memory and bus logs
    fbPkg::pixelWord memory [2**fbPkg::ADDR_W];
    fbPkg::memAddr   beatAdr [$];
    fbPkg::pixelWord beatDat [$];                      // Write beats only
    fbPkg::memAddr   burstBase [$];
    logic            burstWe [$];
    logic            ackHold;                          // Holds off every ack
    logic            cycSeen;
    int              ackWait;

    string           curName;
    int              testErrs, passCount, failCount;
    int              cycles = 0;
    int              cycleLimit = 0;
    int              r;

    frameBufferCtrl i_dut
    (
        .wrWinMin (winMin),
        .wrWinMax (winMax),
        .rdWinMin (winMin),
        .rdWinMax (winMax),
        .*
    );

    initial
    begin
        REF_CLK = 1'b0;
        forever #50 REF_CLK = ~REF_CLK;
    end

    always @(posedge REF_CLK)
    begin
        cycles = cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit)
        begin
            $display("Timeout after %0d cycles, test %s did not finish", cycles, curName);
            $display("TEST FAILED");
            $finish;
        end
    end

    // --------------------------------------------------
    // Wishbone slave, ack after 0 to 3 cycles
    initial
    begin
        void'($urandom(17));
        wbAck   = 1'b0;
        wbDatIn = '0;
        cycSeen = 1'b0;
        ackWait = -1;
        forever
        begin
            @(posedge REF_CLK);
            #5;
            wbAck = 1'b0;
            if (wbCyc && !cycSeen)
            begin
                burstBase.push_back(wbAdr);            // First beat carries the base
                burstWe.push_back(wbWe);
            end
            cycSeen = wbCyc;
            if (wbStb && !ackHold)
            begin
                if (ackWait < 0)
                    ackWait = int'($urandom % 4);
                if (ackWait == 0)
                begin
                    wbAck = 1'b1;
                    beatAdr.push_back(wbAdr);
                    if (wbWe)
                    begin
                        memory[wbAdr] = wbDatOut;
                        beatDat.push_back(wbDatOut);
                    end
                    else
                        wbDatIn = memory[wbAdr];
                end
                ackWait = ackWait - 1;
            end
        end
    end

    function automatic fbPkg::pixelWord fillWord(fbPkg::pixelWord seed, fbPkg::memAddr addr);
        return seed ^ {~addr, addr};
    endfunction

    task automatic checkValue(string field, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERR %s %s expected %h actual %h", curName, field, expected, actual);
            testErrs++;
        end
    endtask

    task automatic nextDrive();
        @(posedge REF_CLK);
        #5;
    endtask

    task automatic waitBusIdle();
        int idle;
        idle = 0;
        while (idle < 6)                               // Longer than the gap between bursts
        begin
            nextDrive();
            idle = wbCyc ? 0 : idle + 1;
        end
    endtask

    task automatic loadWindow(bit isRead);
        nextDrive();
        wrLoad = !isRead;
        rdLoad = isRead;
        nextDrive();
        wrLoad = 1'b0;
        rdLoad = 1'b0;
    endtask

    task automatic pushWords(fbPkg::pixelWord seed, int n, bit obeyFull);
        int i;
        i = 0;
        while (i < n)
        begin
            nextDrive();
            wrPush = !(obeyFull && wrFull);
            wrData = seed + fbPkg::pixelWord'(i);
            if (wrPush)
                i++;
        end
        nextDrive();
        wrPush = 1'b0;
    endtask

    task automatic preloadWindow(int row);
        int            b;
        int            j;
        fbPkg::memAddr addr;
        for (b = 0; b < rowBursts[row]; b++)
            for (j = 0; j < fbPkg::BURST_LEN; j++)
            begin
                addr = rowExp[row][b] + fbPkg::memAddr'(j);
                memory[addr] = fillWord(rowSeed[row], addr);
            end
    endtask

    task automatic popAndCheck(int row);
        int            issued;
        int            got;
        bit            pending;
        fbPkg::memAddr addr;
        issued  = 0;
        got     = 0;
        pending = 1'b0;
        while (got < fbPkg::BURST_LEN * rowBursts[row])
        begin
            nextDrive();
            if (pending)                               // Word of last cycle's pop
            begin
                addr = rowExp[row][got / 8] + fbPkg::memAddr'(got % 8);
                checkValue("popped word", fillWord(rowSeed[row], addr), rdData);
                got++;
            end
            pending = (issued < fbPkg::BURST_LEN * rowBursts[row]) && !rdEmpty;
            rdPop   = pending;
            if (pending)
                issued++;
        end
    endtask

    task automatic checkBases(int row, bit exact);
        int b;
        if (exact || burstBase.size() < rowBursts[row])
            checkValue("burst count", rowBursts[row], burstBase.size());
        for (b = 0; b < rowBursts[row] && b < burstBase.size(); b++)
            checkValue("burst base", 32'(rowExp[row][b]), 32'(burstBase[b]));
    endtask

    task automatic checkWrites(int row);
        int k;
        checkValue("beat count", fbPkg::BURST_LEN * rowBursts[row], beatDat.size());
        for (k = 0; k < beatDat.size() && k < fbPkg::BURST_LEN * rowBursts[row]; k++)
        begin
            checkValue("beat address", 32'(rowExp[row][k / 8]) + k % 8, 32'(beatAdr[k]));
            checkValue("beat data", rowSeed[row] + fbPkg::pixelWord'(k), beatDat[k]);
        end
    endtask

    task automatic readStim();
        int    fd;
        int    n;
        string line;
        fd = $fopen("sim/fbStim.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the stimulus file sim/fbStim.txt");
            return;
        end
        while (rowCount < 16 && $fgets(line, fd) > 0)
        begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", rowName[rowCount],
                        rowMode[rowCount], rowMin[rowCount], rowMax[rowCount],
                        rowSeed[rowCount], rowBursts[rowCount], rowExp[rowCount][0],
                        rowExp[rowCount][1], rowExp[rowCount][2], rowExp[rowCount][3]);
            if (n == 10)                               // Comment lines fall short
            begin
                totalBursts += rowBursts[rowCount];
                rowCount++;
            end
        end
        $fclose(fd);
    endtask

    // --------------------------------------------------
    // Test sequence
    initial
    begin
        RESET_N   = 1'b0;
        wrData    = '0;
        wrPush    = 1'b0;
        wrLoad    = 1'b0;
        rdPop     = 1'b0;
        rdLoad    = 1'b0;
        rdEnable  = 1'b0;
        winMin    = '0;
        winMax    = '0;
        ackHold   = 1'b0;
        curName   = "reset";
        passCount = 0;
        failCount = 0;
        readStim();
        cycleLimit = 40 * totalBursts * (fbPkg::BURST_LEN + 4);
        repeat (16) @(posedge REF_CLK);
        #5;
        RESET_N = 1'b1;

        for (r = 0; r < rowCount; r++)
        begin
            curName  = rowName[r];
            testErrs = 0;
            winMin   = rowMin[r];
            winMax   = rowMax[r];
            beatAdr.delete();
            beatDat.delete();
            burstBase.delete();
            burstWe.delete();
            case (rowMode[r])
                0:
                begin
                    checkValue("wbCyc", 0, wbCyc);
                    checkValue("wbStb", 0, wbStb);
                    checkValue("wrFull", 0, wrFull);
                    checkValue("rdEmpty", 1, rdEmpty);
                end
                1, 4:
                begin
                    loadWindow(1'b0);
                    ackHold = (rowMode[r] == 4);       // Back-pressure case
                    if (ackHold)
                    begin
                        pushWords(rowSeed[r], fbPkg::WR_FIFO_DEPTH + 4, 1'b0);
                        checkValue("wrFull", 1, wrFull);
                    end
                    else
                        pushWords(rowSeed[r], fbPkg::BURST_LEN * rowBursts[r], 1'b1);
                    ackHold = 1'b0;
                    while (beatDat.size() < fbPkg::BURST_LEN * rowBursts[r])
                        nextDrive();
                    waitBusIdle();
                    checkBases(r, 1'b1);
                    checkWrites(r);
                end
                2:
                begin
                    preloadWindow(r);
                    loadWindow(1'b1);
                    rdEnable = 1'b1;
                    popAndCheck(r);
                    rdEnable = 1'b0;
                    waitBusIdle();
                    checkBases(r, 1'b0);
                end
                3:
                begin
                    loadWindow(1'b0);
                    loadWindow(1'b1);
                    pushWords(rowSeed[r], fbPkg::BURST_LEN, 1'b1);
                    rdEnable = 1'b1;                   // Read request rises with the write one
                    while (burstWe.size() == 0)
                        nextDrive();
                    checkValue("first burst wbWe", 1, burstWe[0]);
                    checkValue("first burst base", 32'(rowExp[r][0]), 32'(burstBase[0]));
                    nextDrive();
                    rdEnable = 1'b0;
                    while (beatDat.size() < fbPkg::BURST_LEN)
                        nextDrive();
                    waitBusIdle();
                end
                default:
                begin
                    $display("Test %s has an unknown mode %0d", curName, rowMode[r]);
                    testErrs++;
                end
            endcase
            if (testErrs == 0)
                passCount++;
            else
                failCount++;
            $display("%s %s", (testErrs == 0) ? "PASS" : "FAIL", curName);
        end

        $display("Summary: %0d passed, %0d failed", passCount, failCount);
        if (failCount == 0 && rowCount > 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sim/fbStim.txt
# Columns: name mode winMin winMax seed bursts exp0 exp1 exp2 exp3, all but name in hex
# Modes: 0 reset state, 1 write, 2 read, 3 write and read tie, 4 write back-pressure
# exp0..exp3 are the expected burst base addresses, unused ones are 0000
resetState     0 0000 0000 00000000 0 0000 0000 0000 0000
wrTwoBursts    1 0100 01ff a5000000 2 0100 0108 0000 0000
wrWindowWrap   1 0200 0217 5a000100 4 0200 0208 0210 0200
rdSequence     2 0400 04ff 3c3c0000 2 0400 0408 0000 0000
rdReload       2 0800 080f c3c30000 3 0800 0808 0800 0000
tieWriteFirst  3 0c00 0cff 77000000 1 0c00 0000 0000 0000
wrBackPressure 4 0e00 0eff 11110000 2 0e00 0e08 0000 0000

//--- filelist.f
rtl/fbPkg.sv
rtl/burstFifo.sv
rtl/writeChannel.sv
rtl/readChannel.sv
rtl/burstArbiter.sv
rtl/frameBufferCtrl.sv
sim/fbCtrl_props.sv
sim/tbFrameBuffer.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the frame-buffer controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tbFrameBuffer -f filelist.f -o simFrameBuffer

status=0
./obj_dir/simFrameBuffer > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then
    echo "Simulation failed, exit status ${status}"
    exit 1
fi
echo "Simulation passed"
